// File: rtl/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// ------------------------------
// datapath sizing
// ------------------------------

// FMAs fed in parallel from one staging line
`define MEM_FMA_COUNT 2

// fixed-point word, signed two's complement
`define MEM_WORD_WIDTH 16

// bits after the binary point
`define MEM_FIXED_POINT 10

// results kept per FMA in the write buffer
`define MEM_PHRASES 3

// ------------------------------
// frame buffer side
// ------------------------------

// iteration count per pixel, all ones means never escaped
`define MEM_ITERS_BITS 4

// frame size in pixels
`define MEM_FB_WIDTH 320
`define MEM_FB_HEIGHT 320

// ------------------------------
// controller side
// ------------------------------

// one instruction word per strobe
`define MEM_INSTR_WIDTH 32

`endif

// File: rtl/mem_isa_pkg.sv
package mem_isa_pkg;

    // 4-bit register field of an instruction
    typedef logic [3:0] field_t;

    // 16-bit immediate, same width as a data word
    typedef logic [15:0] imm_t;

    // ------------------------------
    // opcodes shared with the controller
    // ------------------------------
    // only LOADI, LOAD, LOADB, WRITE, OR, SENDITERS and FBSWAP act here
    // the rest run in the controller and look like NOP to this block
    typedef enum logic [3:0] {
        OP_NOP       = 4'd0,
        OP_END       = 4'd1,
        OP_XOR       = 4'd2,
        OP_ADDI      = 4'd3,
        OP_BGE       = 4'd4,
        OP_JUMP      = 4'd5,
        OP_FBSWAP    = 4'd6,
        OP_LOADI     = 4'd7,
        OP_ADD       = 4'd8,
        OP_LOADB     = 4'd9,
        OP_LOAD      = 4'd10,
        OP_WRITEB    = 4'd11,
        OP_WRITE     = 4'd12,
        OP_OR        = 4'd13,
        OP_SENDITERS = 4'd14,
        OP_PAUSE     = 4'd15
    } opcode_e;

    // instruction layout, msb first
    // opcode | field a | immediate | field b | field c
    typedef struct packed {
        opcode_e opcode;
        field_t  field_a;
        imm_t    imm;
        field_t  field_b;
        field_t  field_c;
    } instr_t;

endpackage

// File: rtl/mem_data_pkg.sv
package mem_data_pkg;

    `include "mem_config.svh"

    localparam int FMA_COUNT  = `MEM_FMA_COUNT;
    localparam int WORD_W     = `MEM_WORD_WIDTH;
    localparam int ITERS_W    = `MEM_ITERS_BITS;
    // a, b and c operand per FMA
    localparam int SLOT_COUNT = 3;
    localparam int LINE_WORDS = FMA_COUNT * SLOT_COUNT;

    typedef logic [WORD_W-1:0] word_t;

    // word 0 sits at the msb, word index is fma*3 + slot
    typedef logic [LINE_WORDS*WORD_W-1:0] line_t;

    // phrase p of FMA f at word p*FMA_COUNT + (FMA_COUNT-1-f) from the lsb
    typedef logic [`MEM_PHRASES*FMA_COUNT*WORD_W-1:0] result_buf_t;

    // FMA 0 count at the msb
    typedef logic [FMA_COUNT*ITERS_W-1:0] iters_t;

    typedef logic [$clog2(`MEM_FB_WIDTH*`MEM_FB_HEIGHT)-1:0] pixel_addr_t;

    // lsb of a staging line word
    function automatic int line_lsb(input int word_idx);
        return (LINE_WORDS - 1 - word_idx) * WORD_W;
    endfunction

    // one result word out of the captured buffer
    function automatic word_t buf_word(input result_buf_t rbuf, input int fma, input int phrase);
        return rbuf[(phrase * FMA_COUNT + FMA_COUNT - 1 - fma) * WORD_W +: WORD_W];
    endfunction

    // lsb of one FMA's iteration count
    function automatic int iters_lsb(input int fma);
        return (FMA_COUNT - 1 - fma) * ITERS_W;
    endfunction

endpackage

// File: rtl/instr_front.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module instr_front
    import mem_isa_pkg::*, mem_data_pkg::*;
(
    input  wire                         clk_in,
    input  wire                         rst_in,
    input  wire [`MEM_INSTR_WIDTH-1:0]  instr,
    input  wire                         instr_valid,
    input  result_buf_t                 result_buf,
    input  wire                         result_valid,
    output logic                        loadi_stb,
    output logic                        load_stb,
    output logic                        loadb_stb,
    output logic                        write_stb,
    output logic                        or_stb,
    output logic                        send_stb,
    output logic                        swap_stb,
    output field_t                      field_a,
    output field_t                      field_b,
    output field_t                      field_c,
    output imm_t                        imm,
    output result_buf_t                 captured_buf
);

    instr_t ins;

    // ------------------------------
    // instruction split
    // ------------------------------
    assign ins = instr_t'(instr);

    assign field_a = ins.field_a;
    assign field_b = ins.field_b;
    assign field_c = ins.field_c;
    assign imm     = ins.imm;

    // one strobe per opcode this block acts on
    // controller-only opcodes fall through with no strobe
    assign loadi_stb = instr_valid && (ins.opcode == OP_LOADI);
    assign load_stb  = instr_valid && (ins.opcode == OP_LOAD);
    assign loadb_stb = instr_valid && (ins.opcode == OP_LOADB);
    assign write_stb = instr_valid && (ins.opcode == OP_WRITE);
    assign or_stb    = instr_valid && (ins.opcode == OP_OR);
    assign send_stb  = instr_valid && (ins.opcode == OP_SENDITERS);
    assign swap_stb  = instr_valid && (ins.opcode == OP_FBSWAP);

    // ------------------------------
    // FMA result capture
    // ------------------------------
    // last write buffer seen from the FMAs
    // usable by LOADB and OR from the cycle after result_valid
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            captured_buf <= '0;
        end else if (result_valid) begin
            captured_buf <= result_buf;
        end
    end

endmodule

`default_nettype wire

// File: rtl/line_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module line_stage
    import mem_isa_pkg::*, mem_data_pkg::*;
(
    input  wire         clk_in,
    input  wire         rst_in,
    input  wire         loadi_stb,
    input  wire         load_stb,
    input  wire         loadb_stb,
    input  field_t      field_a,
    input  field_t      field_b,
    input  field_t      field_c,
    input  imm_t        imm,
    input  word_t       reg_b,
    input  word_t       reg_c,
    input  result_buf_t captured_buf,
    output line_t       line
);

    line_t  line_next;
    field_t shuffle_code [SLOT_COUNT];
    word_t  ramp;

    // slot a, b, c take their shuffle code from field a, b, c
    assign shuffle_code = '{field_a, field_b, field_c};

    // one shuffled word
    // 0 zero, 1..3 phrase, 4..6 doubled phrase, 13..15 negated phrase
    // codes 7..12 leave the word as it was
    function automatic word_t shuffle_word(
        input field_t      code,
        input result_buf_t rbuf,
        input int          fma,
        input word_t       keep
    );
        word_t w;
        w = keep;
        if (code == 4'd0) begin
            w = '0;
        end else if (code <= 4'd3) begin
            w = buf_word(rbuf, fma, int'(code) - 1);
        end else if (code <= 4'd6) begin
            // doubling drops the msb, wraps like the FMA datapath
            w = buf_word(rbuf, fma, int'(code) - 4) << 1;
        end else if (code >= 4'd13) begin
            w = -buf_word(rbuf, fma, 15 - int'(code));
        end
        return w;
    endfunction

    // ------------------------------
    // next line
    // ------------------------------
    always_comb begin
        line_next = line;
        ramp      = '0;

        // immediate into one word, words past the line are ignored
        if (loadi_stb && (int'(field_a) < LINE_WORDS)) begin
            line_next[line_lsb(int'(field_a)) +: WORD_W] = imm;
        end

        // ramp reg_b + f*reg_c into one slot of every FMA
        // wraps modulo 2^16
        if (load_stb && (int'(field_a) < SLOT_COUNT)) begin
            for (int f = 0; f < FMA_COUNT; f++) begin
                ramp = reg_b + word_t'(f) * reg_c;
                line_next[line_lsb(f * SLOT_COUNT + int'(field_a)) +: WORD_W] = ramp;
            end
        end

        // shuffle captured results, each FMA on its own phrases
        if (loadb_stb) begin
            for (int f = 0; f < FMA_COUNT; f++) begin
                for (int s = 0; s < SLOT_COUNT; s++) begin
                    line_next[line_lsb(f * SLOT_COUNT + s) +: WORD_W] =
                        shuffle_word(shuffle_code[s], captured_buf, f,
                                     line[line_lsb(f * SLOT_COUNT + s) +: WORD_W]);
                end
            end
        end
    end

    // ------------------------------
    // staging register
    // ------------------------------
    // a change here is seen by a WRITE in the very next cycle
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            line <= '0;
        end else begin
            line <= line_next;
        end
    end

endmodule

`default_nettype wire

// File: rtl/escape_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module escape_tracker
    import mem_data_pkg::*;
(
    input  wire         clk_in,
    input  wire         rst_in,
    input  wire         or_stb,
    input  wire         send_stb,
    input  word_t       reg_a,
    input  result_buf_t captured_buf,
    output iters_t      iters
);

    // |z|^2 >= 4 in fixed point
    localparam word_t ESCAPE_LIMIT = word_t'(4 << `MEM_FIXED_POINT);

    logic [FMA_COUNT-1:0] escaped;
    word_t                mag;

    // ------------------------------
    // divergence test
    // ------------------------------
    // phrase 2 holds the squared magnitude
    // the top bit is dropped before the compare
    always_comb begin
        mag = '0;
        for (int f = 0; f < FMA_COUNT; f++) begin
            mag        = buf_word(captured_buf, f, 2);
            escaped[f] = {1'b0, mag[WORD_W-2:0]} >= ESCAPE_LIMIT;
        end
    end

    // ------------------------------
    // per-FMA counts
    // ------------------------------
    // all ones means still bounded
    // only the first escape of a pixel is kept
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            iters <= '1;
        end else if (send_stb) begin
            // counts leave with SENDITERS, start over for the next pixels
            iters <= '1;
        end else if (or_stb) begin
            for (int f = 0; f < FMA_COUNT; f++) begin
                if ((iters[iters_lsb(f) +: ITERS_W] == '1) && escaped[f]) begin
                    // iteration number divided by 4 to fit the count
                    iters[iters_lsb(f) +: ITERS_W] <= reg_a[5 -: `MEM_ITERS_BITS];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/issue_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module issue_port
    import mem_isa_pkg::*, mem_data_pkg::*;
(
    input  wire         clk_in,
    input  wire         rst_in,
    input  wire         write_stb,
    input  wire         send_stb,
    input  wire         swap_stb,
    input  field_t      field_a,
    input  field_t      field_b,
    input  line_t       line,
    input  iters_t      iters,
    input  word_t       reg_a,
    input  word_t       reg_b,
    output line_t       abc,
    output logic        use_new_c,
    output logic        fma_out_enable,
    output logic        abc_valid,
    output logic        frame_swap,
    output logic        iters_valid,
    output iters_t      iters_out,
    output pixel_addr_t pixel_addr
);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            abc            <= '0;
            use_new_c      <= 1'b0;
            fma_out_enable <= 1'b0;
            abc_valid      <= 1'b0;
            frame_swap     <= 1'b0;
            iters_valid    <= 1'b0;
            iters_out      <= '1;
            pixel_addr     <= '0;
        end else begin
            // ------------------------------
            // single-cycle pulses
            // ------------------------------
            abc_valid   <= write_stb;
            iters_valid <= send_stb;
            frame_swap  <= swap_stb;

            // FMAs only emit a result at the end of a chained dot product
            fma_out_enable <= write_stb && (field_b == 4'd1);

            // ------------------------------
            // toward the FMAs
            // ------------------------------
            if (write_stb) begin
                abc       <= line;
                // 1 takes c from the line, anything else keeps the FMA's own c
                use_new_c <= (field_a == 4'd1);
            end

            // ------------------------------
            // toward the frame buffer
            // ------------------------------
            if (send_stb) begin
                iters_out  <= iters;
                // x from reg_a, y from reg_b
                // two registers since one word cannot cover the frame
                pixel_addr <= pixel_addr_t'(`MEM_FB_HEIGHT * reg_a + reg_b);
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/gpu_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module gpu_memory
    import mem_isa_pkg::*, mem_data_pkg::*;
(
    input  wire                         clk_in,
    input  wire                         rst_in,
    input  wire [`MEM_INSTR_WIDTH-1:0]  instr,
    input  wire                         instr_valid,
    input  word_t                       reg_a,
    input  word_t                       reg_b,
    input  word_t                       reg_c,
    input  result_buf_t                 result_buf,
    input  wire                         result_valid,
    output line_t                       abc,
    output logic                        use_new_c,
    output logic                        fma_out_enable,
    output logic                        abc_valid,
    output logic                        frame_swap,
    output logic                        iters_valid,
    output iters_t                      iters,
    output pixel_addr_t                 pixel_addr
);

    // decoded strobes
    logic        loadi_stb;
    logic        load_stb;
    logic        loadb_stb;
    logic        write_stb;
    logic        or_stb;
    logic        send_stb;
    logic        swap_stb;

    // instruction fields
    field_t      field_a;
    field_t      field_b;
    field_t      field_c;
    imm_t        imm;

    result_buf_t captured_buf;
    line_t       line;
    iters_t      escape_iters;

    // ------------------------------
    // input side
    // ------------------------------
    instr_front front (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .result_buf   (result_buf),
        .result_valid (result_valid),
        .loadi_stb    (loadi_stb),
        .load_stb     (load_stb),
        .loadb_stb    (loadb_stb),
        .write_stb    (write_stb),
        .or_stb       (or_stb),
        .send_stb     (send_stb),
        .swap_stb     (swap_stb),
        .field_a      (field_a),
        .field_b      (field_b),
        .field_c      (field_c),
        .imm          (imm),
        .captured_buf (captured_buf)
    );

    // ------------------------------
    // processing
    // ------------------------------
    line_stage stage (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .loadi_stb    (loadi_stb),
        .load_stb     (load_stb),
        .loadb_stb    (loadb_stb),
        .field_a      (field_a),
        .field_b      (field_b),
        .field_c      (field_c),
        .imm          (imm),
        .reg_b        (reg_b),
        .reg_c        (reg_c),
        .captured_buf (captured_buf),
        .line         (line)
    );

    escape_tracker tracker (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .or_stb       (or_stb),
        .send_stb     (send_stb),
        .reg_a        (reg_a),
        .captured_buf (captured_buf),
        .iters        (escape_iters)
    );

    // ------------------------------
    // output side
    // ------------------------------
    issue_port port (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .write_stb      (write_stb),
        .send_stb       (send_stb),
        .swap_stb       (swap_stb),
        .field_a        (field_a),
        .field_b        (field_b),
        .line           (line),
        .iters          (escape_iters),
        .reg_a          (reg_a),
        .reg_b          (reg_b),
        .abc            (abc),
        .use_new_c      (use_new_c),
        .fma_out_enable (fma_out_enable),
        .abc_valid      (abc_valid),
        .frame_swap     (frame_swap),
        .iters_valid    (iters_valid),
        .iters_out      (iters),
        .pixel_addr     (pixel_addr)
    );

endmodule

`default_nettype wire

// File: tb/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk
);

    // 8 ns period, 125 MHz
    localparam real HALF_PERIOD = 4.0;

    // free-running clock, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD) clk = ~clk;
        end
    end

endmodule

// File: tb/gpu_memory_tb.sv
`timescale 1ns/1ps

`include "mem_config.svh"

module gpu_memory_tb
    import mem_isa_pkg::*, mem_data_pkg::*;
();

    localparam int FMAS  = `MEM_FMA_COUNT;
    localparam int WORDS = FMAS * 3;
    // |z|^2 >= 4 in fixed point
    localparam int ESCAPE_LIMIT = 4 << `MEM_FIXED_POINT;
    // the five tests take about 110 cycles
    localparam int TIMEOUT_CYCLES = 2000;

    logic                        clk_in;
    logic                        rst_in;
    logic [`MEM_INSTR_WIDTH-1:0] instr;
    logic                        instr_valid;
    word_t                       reg_a;
    word_t                       reg_b;
    word_t                       reg_c;
    result_buf_t                 result_buf;
    logic                        result_valid;
    line_t                       abc;
    logic                        use_new_c;
    logic                        fma_out_enable;
    logic                        abc_valid;
    logic                        frame_swap;
    logic                        iters_valid;
    iters_t                      iters;
    pixel_addr_t                 pixel_addr;

    // reference state
    word_t       exp_line [WORDS];
    word_t       exp_buf [FMAS][3];
    logic [3:0]  exp_iters [FMAS];
    pixel_addr_t last_addr;

    int          cycle_count = 0;
    int unsigned seed_value;

    clk_gen clock (
        .clk (clk_in)
    );

    gpu_memory UUT (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .instr          (instr),
        .instr_valid    (instr_valid),
        .reg_a          (reg_a),
        .reg_b          (reg_b),
        .reg_c          (reg_c),
        .result_buf     (result_buf),
        .result_valid   (result_valid),
        .abc            (abc),
        .use_new_c      (use_new_c),
        .fma_out_enable (fma_out_enable),
        .abc_valid      (abc_valid),
        .frame_swap     (frame_swap),
        .iters_valid    (iters_valid),
        .iters          (iters),
        .pixel_addr     (pixel_addr)
    );

    // ------------------------------
    // reference packing
    // ------------------------------
    // word 0 at the msb
    function automatic line_t packed_line();
        line_t l;
        l = '0;
        for (int w = 0; w < WORDS; w++) begin
            l[(WORDS - 1 - w) * 16 +: 16] = exp_line[w];
        end
        return l;
    endfunction

    // FMA 0 count at the msb
    function automatic iters_t packed_iters();
        iters_t it;
        it = '0;
        for (int f = 0; f < FMAS; f++) begin
            it[(FMAS - 1 - f) * 4 +: 4] = exp_iters[f];
        end
        return it;
    endfunction

    // one word of LOADB from its shuffle code
    function automatic word_t shuffle_ref(input int code, input int f, input word_t keep);
        if (code == 0) begin
            return '0;
        end
        if (code >= 1 && code <= 3) begin
            return exp_buf[f][code - 1];
        end
        if (code >= 4 && code <= 6) begin
            return word_t'(exp_buf[f][code - 4] * 2);
        end
        if (code >= 13) begin
            return word_t'(0 - exp_buf[f][15 - code]);
        end
        // 7..12 keep the word
        return keep;
    endfunction

    task automatic check_value(input string what, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------
    // one-cycle strobe
    // returns at the falling edge after the sampling edge
    task automatic issue(input logic [3:0] op, input field_t fa, input imm_t im,
                         input field_t fb, input field_t fc,
                         input word_t ra, input word_t rb, input word_t rc);
        @(posedge clk_in);
        instr       <= {op, fa, im, fb, fc};
        instr_valid <= 1'b1;
        reg_a       <= ra;
        reg_b       <= rb;
        reg_c       <= rc;
        @(posedge clk_in);
        instr       <= '0;
        instr_valid <= 1'b0;
        @(negedge clk_in);
    endtask

    // exp_buf driven as FMA results
    // phrase p of FMA f at word p*FMAS + (FMAS-1-f)
    task automatic capture_results();
        result_buf_t b;
        b = '0;
        for (int f = 0; f < FMAS; f++) begin
            for (int p = 0; p < 3; p++) begin
                b[(p * FMAS + FMAS - 1 - f) * 16 +: 16] = exp_buf[f][p];
            end
        end
        @(posedge clk_in);
        result_buf   <= b;
        result_valid <= 1'b1;
        @(posedge clk_in);
        result_valid <= 1'b0;
        @(negedge clk_in);
    endtask

    task automatic write_and_check(input field_t fa, input field_t fb);
        issue(OP_WRITE, fa, '0, fb, '0, '0, '0, '0);
        check_value("abc", abc, packed_line());
        check_value("abc_valid", abc_valid, 1'b1);
        check_value("use_new_c", use_new_c, fa == 4'd1);
        check_value("fma_out_enable", fma_out_enable, fb == 4'd1);
        // pulses drop while abc and use_new_c hold
        @(negedge clk_in);
        check_value("abc_valid after pulse", abc_valid, 1'b0);
        check_value("fma_out_enable after pulse", fma_out_enable, 1'b0);
        check_value("use_new_c held", use_new_c, fa == 4'd1);
        check_value("abc held", abc, packed_line());
    endtask

    // OR on the reference counts before the DUT
    task automatic or_and_check(input word_t ra);
        for (int f = 0; f < FMAS; f++) begin
            if (exp_iters[f] == 4'hf && (exp_buf[f][2] & 16'h7fff) >= ESCAPE_LIMIT) begin
                exp_iters[f] = ra[5:2];
            end
        end
        issue(OP_OR, '0, '0, '0, '0, ra, '0, '0);
        check_value("iters_valid on OR", iters_valid, 1'b0);
    endtask

    task automatic send_and_check(input word_t x, input word_t y);
        iters_t sent;
        sent      = packed_iters();
        last_addr = pixel_addr_t'((`MEM_FB_HEIGHT * int'(x) + int'(y)) % (1 << 17));
        issue(OP_SENDITERS, '0, '0, '0, '0, x, y, '0);
        check_value("iters", iters, sent);
        check_value("iters_valid", iters_valid, 1'b1);
        check_value("pixel_addr", pixel_addr, last_addr);
        // counts start over after a send
        for (int f = 0; f < FMAS; f++) begin
            exp_iters[f] = 4'hf;
        end
        @(negedge clk_in);
        check_value("iters_valid after pulse", iters_valid, 1'b0);
        check_value("iters held", iters, sent);
    endtask

    // ------------------------------
    // tests
    // ------------------------------
    task automatic reset_defaults();
        check_value("abc_valid after reset", abc_valid, 1'b0);
        check_value("fma_out_enable after reset", fma_out_enable, 1'b0);
        check_value("frame_swap after reset", frame_swap, 1'b0);
        check_value("iters_valid after reset", iters_valid, 1'b0);
        check_value("use_new_c after reset", use_new_c, 1'b0);
        check_value("pixel_addr after reset", pixel_addr, '0);
        // staging line still all zero
        write_and_check(4'd0, 4'd0);
    endtask

    task automatic load_and_ramp();
        imm_t  value;
        word_t base;
        word_t step;
        for (int w = 0; w < WORDS; w++) begin
            value       = imm_t'($urandom);
            exp_line[w] = value;
            issue(OP_LOADI, field_t'(w), value, '0, '0, '0, '0, '0);
        end
        base = word_t'($urandom);
        step = word_t'($urandom);
        // ramp into slot c
        issue(OP_LOAD, 4'd2, '0, '0, '0, '0, base, step);
        for (int f = 0; f < FMAS; f++) begin
            exp_line[f * 3 + 2] = word_t'(base + f * step);
        end
        write_and_check(4'd1, 4'd1);
        write_and_check(4'd0, 4'd2);
    endtask

    task automatic loadb_codes();
        int codes [5][3];
        codes = '{'{0, 1, 2}, '{3, 4, 5}, '{6, 13, 14}, '{15, 9, 7}, '{12, 0, 1}};
        for (int f = 0; f < FMAS; f++) begin
            for (int p = 0; p < 3; p++) begin
                exp_buf[f][p] = word_t'($urandom);
            end
        end
        capture_results();
        for (int t = 0; t < 5; t++) begin
            issue(OP_LOADB, field_t'(codes[t][0]), '0, field_t'(codes[t][1]),
                  field_t'(codes[t][2]), '0, '0, '0);
            for (int f = 0; f < FMAS; f++) begin
                for (int s = 0; s < 3; s++) begin
                    exp_line[f * 3 + s] = shuffle_ref(codes[t][s], f, exp_line[f * 3 + s]);
                end
            end
            write_and_check(4'd0, 4'd0);
        end
    endtask

    task automatic escape_counts();
        // FMA 0 exactly at the limit
        // FMA 1 just below it with the top bit set
        exp_buf[0][2] = word_t'(ESCAPE_LIMIT);
        exp_buf[1][2] = word_t'(16'h8000 | (ESCAPE_LIMIT - 1));
        capture_results();
        or_and_check(16'h0014);
        // FMA 0 escapes again and must keep its first count
        exp_buf[0][2] = 16'h7fff;
        exp_buf[1][2] = word_t'(ESCAPE_LIMIT - 1);
        capture_results();
        or_and_check(16'h0028);
        send_and_check(16'd0, 16'd0);
        send_and_check(16'd1, 16'd2);
        // FMA 0 stays below the limit
        // FMA 1 sits at the limit under a set top bit
        exp_buf[0][2] = 16'h0100;
        exp_buf[1][2] = 16'h9000;
        capture_results();
        or_and_check(16'h0020);
        send_and_check(16'd3, 16'd4);
    endtask

    task automatic address_and_swap();
        word_t x;
        word_t y;
        for (int n = 0; n < 4; n++) begin
            x = word_t'($urandom_range(`MEM_FB_WIDTH - 1, 0));
            y = word_t'($urandom_range(`MEM_FB_HEIGHT - 1, 0));
            send_and_check(x, y);
        end
        // last pixel of the frame
        send_and_check(16'd319, 16'd319);
        issue(OP_FBSWAP, '0, '0, '0, '0, '0, '0, '0);
        check_value("frame_swap", frame_swap, 1'b1);
        check_value("abc_valid on swap", abc_valid, 1'b0);
        check_value("iters_valid on swap", iters_valid, 1'b0);
        check_value("fma_out_enable on swap", fma_out_enable, 1'b0);
        check_value("abc on swap", abc, packed_line());
        // last WRITE had field a = 0
        check_value("use_new_c on swap", use_new_c, 1'b0);
        check_value("iters on swap", iters, packed_iters());
        check_value("pixel_addr on swap", pixel_addr, last_addr);
        @(negedge clk_in);
        check_value("frame_swap after pulse", frame_swap, 1'b0);
        // controller-only opcode acts like NOP
        issue(OP_ADD, 4'd1, 16'hffff, 4'd1, 4'd1, 16'h0fff, 16'h0fff, 16'h0fff);
        check_value("abc_valid on ADD", abc_valid, 1'b0);
        check_value("pixel_addr on ADD", pixel_addr, last_addr);
        write_and_check(4'd0, 4'd0);
    endtask

    // ------------------------------
    // run control
    // ------------------------------
    always @(posedge clk_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    initial begin
        seed_value   = $urandom(32'hd962_b3dc);
        rst_in       = 1'b1;
        instr        = '0;
        instr_valid  = 1'b0;
        reg_a        = '0;
        reg_b        = '0;
        reg_c        = '0;
        result_buf   = '0;
        result_valid = 1'b0;
        last_addr    = '0;
        for (int w = 0; w < WORDS; w++) begin
            exp_line[w] = '0;
        end
        for (int f = 0; f < FMAS; f++) begin
            exp_iters[f] = 4'hf;
            for (int p = 0; p < 3; p++) begin
                exp_buf[f][p] = '0;
            end
        end

        repeat (10) @(posedge clk_in);
        rst_in <= 1'b0;
        @(negedge clk_in);

        reset_defaults();
        load_and_ramp();
        loadb_codes();
        escape_counts();
        address_and_swap();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: flist.f
+incdir+rtl
rtl/mem_isa_pkg.sv
rtl/mem_data_pkg.sv
rtl/instr_front.sv
rtl/line_stage.sv
rtl/escape_tracker.sv
rtl/issue_port.sv
rtl/gpu_memory.sv
tb/clk_gen.sv
tb/gpu_memory_tb.sv
